/* design/amo_unit.sv */
`timescale 1ns/1ps

module amo_unit
    import dcache_pkg::*;
(
    input  logic      CLK,
    input  core_req_t req,
    input  line_t     bank_words,
    output word_t     old_word,
    output word_t     new_word
);

    logic [WORD_SEL_WIDTH-1:0] word_sel;
    word_t                     result;

    assign word_sel = req.addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
    assign old_word = bank_words[word_sel*WORD_WIDTH +: WORD_WIDTH];

    always_comb begin
        result = old_word;
        if (req.op == op_store) begin
            // strobe merge happens in the bank
            result = req.wdata;
        end else if (req.op == op_amo) begin
            case (req.amo)
                amo_swap: result = req.wdata;
                amo_add:  result = old_word + req.wdata;
                amo_xor:  result = old_word ^ req.wdata;
                amo_and:  result = old_word & req.wdata;
                amo_or:   result = old_word | req.wdata;
                amo_min: begin
                    result = ($signed(old_word) < $signed(req.wdata)) ? old_word : req.wdata;
                end
                amo_max: begin
                    result = ($signed(old_word) > $signed(req.wdata)) ? old_word : req.wdata;
                end
                amo_minu: result = (old_word < req.wdata) ? old_word : req.wdata;
                amo_maxu: result = (old_word > req.wdata) ? old_word : req.wdata;
                default:  result = old_word;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        new_word <= result;
    end

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(DEPTH),
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   CLK,
    input  logic                   RST,
    input  core_req_t              req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output word_t                  rsp_data,
    output logic                   l2_rd_valid,
    output line_addr_t             l2_rd_addr,
    input  logic                   l2_fill_valid,
    output logic                   l2_wb_valid,
    output l2_wb_t                 l2_wb,
    input  logic                   l2_wb_done,
    output logic [INDEX_WIDTH-1:0] tag_index,
    output logic [TAG_WIDTH-1:0]   req_tag,
    output logic                   tag_wr,
    output logic                   tag_wr_dirty,
    output logic                   dirty_set,
    input  logic                   lookup_hit,
    input  logic                   lookup_dirty,
    input  logic [TAG_WIDTH-1:0]   victim_tag,
    output logic [INDEX_WIDTH-1:0] bank_index,
    output logic [BLOCK_WORDS-1:0] bank_wr,
    output logic                   bank_fill,
    output strb_t                  bank_strb,
    output word_t                  bank_wdata,
    input  line_t                  bank_words,
    output core_req_t              cur_req,
    input  word_t                  old_word,
    input  word_t                  new_word
);

    ctrl_state_e               state;
    logic                      upd_wait;
    logic                      upd_fire;
    logic                      fill_now;
    logic                      is_write;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic [INDEX_WIDTH-1:0]    req_index;

    assign req_ready = (state == IDLE);
    assign word_sel  = cur_req.addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
    assign req_index = cur_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag   = cur_req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    // while idle the arrays are read with the incoming address,
    // so tag and words are ready in LOOKUP
    assign tag_index  = req_ready ? req.addr[OFFSET_WIDTH +: INDEX_WIDTH] : req_index;
    assign bank_index = tag_index;
    assign l2_rd_addr = cur_req.addr[ADDR_WIDTH-1:OFFSET_WIDTH];

    assign fill_now = (state == REFILL_WAIT) && l2_fill_valid;
    assign upd_fire = (state == UPDATE) && !upd_wait;
    assign is_write = (cur_req.op != op_load);

    // refill installs a clean line, a store or AMO dirties it
    assign tag_wr       = fill_now;
    assign tag_wr_dirty = fill_now || (upd_fire && is_write);
    assign dirty_set    = !fill_now;

    assign bank_fill  = fill_now;
    assign bank_strb  = (cur_req.op == op_store) ? cur_req.wstrb : '1;
    assign bank_wdata = new_word;

    always_comb begin
        bank_wr = '0;
        if (fill_now) begin
            bank_wr = '1;
        end else if (upd_fire && is_write) begin
            bank_wr[word_sel] = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= IDLE;
            upd_wait    <= 1'b0;
            rsp_valid   <= 1'b0;
            l2_rd_valid <= 1'b0;
            l2_wb_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lookup_hit) begin
                        // AMO result needs one more cycle
                        upd_wait <= (cur_req.op == op_amo);
                        state    <= UPDATE;
                    end else if (lookup_dirty) begin
                        l2_wb_valid <= 1'b1;
                        state       <= WRITEBACK;
                    end else begin
                        state <= REFILL_REQ;
                    end
                end
                WRITEBACK: begin
                    if (l2_wb_done) begin
                        l2_wb_valid <= 1'b0;
                        state       <= REFILL_REQ;
                    end
                end
                REFILL_REQ: begin
                    l2_rd_valid <= 1'b1;
                    state       <= REFILL_WAIT;
                end
                REFILL_WAIT: begin
                    if (l2_fill_valid) begin
                        l2_rd_valid <= 1'b0;
                        // filled words reach new_word one cycle later
                        upd_wait    <= 1'b1;
                        state       <= UPDATE;
                    end
                end
                UPDATE: begin
                    if (upd_wait) begin
                        upd_wait <= 1'b0;
                    end else begin
                        rsp_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (req_ready && req_valid) begin
            cur_req <= req;
        end
        // victim is still in the arrays during LOOKUP
        if (state == LOOKUP) begin
            l2_wb.addr <= {victim_tag, req_index};
            l2_wb.data <= bank_words;
        end
        if (upd_fire) begin
            rsp_data <= old_word;
        end
    end

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    // core word and address geometry
    localparam int WORD_WIDTH     = 64;
    localparam int ADDR_WIDTH     = 32;
    localparam int BLOCK_WORDS    = 4;
    localparam int OFFSET_WIDTH   = 5;
    localparam int WORD_SEL_WIDTH = 2;

    typedef logic [WORD_WIDTH-1:0]               word_t;
    typedef logic [WORD_WIDTH/8-1:0]             strb_t;
    typedef logic [ADDR_WIDTH-1:0]               addr_t;
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0]  line_addr_t;
    typedef logic [BLOCK_WORDS*WORD_WIDTH-1:0]   line_t;

    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_amo
    } op_e;

    // 64-bit atomics only
    typedef enum logic [3:0] {
        amo_swap,
        amo_add,
        amo_xor,
        amo_and,
        amo_or,
        amo_min,
        amo_max,
        amo_minu,
        amo_maxu
    } amo_e;

    typedef struct packed {
        op_e   op;
        amo_e  amo;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } core_req_t;

    // victim line on its way to L2
    typedef struct packed {
        line_addr_t addr;
        line_t      data;
    } l2_wb_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        UPDATE
    } ctrl_state_e;

endpackage

/* design/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(DEPTH),
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic       CLK,
    input  logic       RST,
    input  core_req_t  req,
    input  logic       req_valid,
    output logic       req_ready,
    output logic       rsp_valid,
    output word_t      rsp_data,
    output logic       l2_rd_valid,
    output line_addr_t l2_rd_addr,
    input  logic       l2_fill_valid,
    input  line_t      l2_fill_data,
    output logic       l2_wb_valid,
    output l2_wb_t     l2_wb,
    input  logic       l2_wb_done
);

    logic [INDEX_WIDTH-1:0] tag_index;
    logic [INDEX_WIDTH-1:0] bank_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [TAG_WIDTH-1:0]   victim_tag;
    logic                   tag_wr;
    logic                   tag_wr_dirty;
    logic                   dirty_set;
    logic                   lookup_hit;
    logic                   lookup_dirty;
    logic [BLOCK_WORDS-1:0] bank_wr;
    logic                   bank_fill;
    strb_t                  bank_strb;
    word_t                  bank_wdata;
    line_t                  bank_words;
    core_req_t              cur_req;
    word_t                  old_word;
    word_t                  new_word;

    dcache_ctrl #(.DEPTH(DEPTH)) ctrl0 (
        .CLK, .RST, .req, .req_valid, .req_ready, .rsp_valid, .rsp_data,
        .l2_rd_valid, .l2_rd_addr, .l2_fill_valid, .l2_wb_valid, .l2_wb, .l2_wb_done,
        .tag_index, .req_tag, .tag_wr, .tag_wr_dirty, .dirty_set,
        .lookup_hit, .lookup_dirty, .victim_tag,
        .bank_index, .bank_wr, .bank_fill, .bank_strb, .bank_wdata, .bank_words,
        .cur_req, .old_word, .new_word
    );

    tag_store #(.DEPTH(DEPTH)) tags0 (
        .CLK, .RST, .tag_index, .req_tag, .tag_wr, .tag_wr_dirty, .dirty_set,
        .lookup_hit, .lookup_dirty, .victim_tag
    );

    // one bank per word of a line, word 0 in the low bits
    for (genvar i = 0; i < BLOCK_WORDS; i++) begin : g_bank
        word_bank #(.DEPTH(DEPTH)) bank (
            .CLK,
            .bank_index,
            .wr(bank_wr[i]),
            .fill(bank_fill),
            .strb(bank_strb),
            .wdata(bank_wdata),
            .fill_word(l2_fill_data[i*WORD_WIDTH +: WORD_WIDTH]),
            .rdata(bank_words[i*WORD_WIDTH +: WORD_WIDTH])
        );
    end

    amo_unit amo0 (
        .CLK, .req(cur_req), .bank_words, .old_word, .new_word
    );

endmodule

/* design/tag_store.sv */
`timescale 1ns/1ps

module tag_store
    import dcache_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(DEPTH),
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic [INDEX_WIDTH-1:0] tag_index,
    input  logic [TAG_WIDTH-1:0]   req_tag,
    input  logic                   tag_wr,
    input  logic                   tag_wr_dirty,
    input  logic                   dirty_set,
    output logic                   lookup_hit,
    output logic                   lookup_dirty,
    output logic [TAG_WIDTH-1:0]   victim_tag
);

    logic [TAG_WIDTH-1:0] tags [DEPTH];
    logic [DEPTH-1:0]     valid;
    logic [DEPTH-1:0]     dirty;
    logic                 valid_q;
    logic                 dirty_q;

    // stored tag of the indexed set
    always_ff @(posedge CLK) begin
        if (tag_wr) begin
            tags[tag_index] <= req_tag;
        end
        victim_tag <= tags[tag_index];
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid   <= '0;
            dirty   <= '0;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            if (tag_wr) begin
                valid[tag_index] <= 1'b1;
            end
            if (tag_wr_dirty) begin
                dirty[tag_index] <= dirty_set;
            end
            valid_q <= valid[tag_index];
            dirty_q <= dirty[tag_index];
        end
    end

    assign lookup_hit   = valid_q && (victim_tag == req_tag);
    assign lookup_dirty = valid_q && dirty_q;

endmodule

/* design/word_bank.sv */
`timescale 1ns/1ps

module word_bank
    import dcache_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(DEPTH)
) (
    input  logic                   CLK,
    input  logic [INDEX_WIDTH-1:0] bank_index,
    input  logic                   wr,
    input  logic                   fill,
    input  strb_t                  strb,
    input  word_t                  wdata,
    input  word_t                  fill_word,
    output word_t                  rdata
);

    word_t mem [DEPTH];
    word_t merged;

    // fill replaces the word, a core write merges bytes
    always_comb begin
        merged = mem[bank_index];
        if (fill) begin
            merged = fill_word;
        end else begin
            for (int b = 0; b < WORD_WIDTH / 8; b++) begin
                if (strb[b]) begin
                    merged[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    end

    // write-first read port
    always_ff @(posedge CLK) begin
        if (wr) begin
            mem[bank_index] <= merged;
        end
        rdata <= wr ? merged : mem[bank_index];
    end

endmodule

/* tb.f */
design/dcache_pkg.sv
design/tag_store.sv
design/word_bank.sv
design/amo_unit.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/l2_mem_model.sv
test/dcache_tb.sv

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int    DEPTH      = 16;
    localparam int    POOL_LINES = 3 * DEPTH;
    localparam addr_t POOL_BASE  = 32'h0004_0000;
    localparam int    N_LOADS    = 60;
    localparam int    N_STORES   = 40;
    localparam int    N_AMOS     = 36;
    localparam int    N_MIX      = 200;
    localparam int    N_REPEAT   = 30;
    localparam int    TOTAL_REQ  = N_LOADS + 2 * N_STORES + 2 * N_AMOS + N_MIX + 2 * N_REPEAT;

    logic       CLK;
    logic       RST;
    core_req_t  req;
    logic       req_valid;
    logic       req_ready;
    logic       rsp_valid;
    word_t      rsp_data;
    logic       l2_rd_valid;
    line_addr_t l2_rd_addr;
    logic       l2_fill_valid;
    line_t      l2_fill_data;
    logic       l2_wb_valid;
    l2_wb_t     l2_wb;
    logic       l2_wb_done;

    logic [31:0]      seed = 32'hbc62;
    word_t            ref_mem [addr_t];
    line_addr_t       shadow_line [DEPTH];
    logic [DEPTH-1:0] shadow_valid;
    logic [DEPTH-1:0] shadow_dirty;
    string            test_name;
    int               n_checks = 0;
    int               n_errors = 0;
    int               n_tests = 0;
    int               n_wb = 0;
    int               checks_at_start;
    int               errors_at_start;

    dcache_top #(.DEPTH(DEPTH)) dut0 (
        .CLK, .RST, .req, .req_valid, .req_ready, .rsp_valid, .rsp_data,
        .l2_rd_valid, .l2_rd_addr, .l2_fill_valid, .l2_fill_data,
        .l2_wb_valid, .l2_wb, .l2_wb_done
    );

    l2_mem_model l2_0 (
        .CLK, .RST, .l2_rd_valid, .l2_rd_addr, .l2_fill_valid, .l2_fill_data,
        .l2_wb_valid, .l2_wb, .l2_wb_done
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        repeat (16 + TOTAL_REQ * 200) @(posedge CLK);
        $display("error: run did not finish within %0d cycles", 16 + TOTAL_REQ * 200);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w[63:32] = next_rand();
        w[31:0]  = next_rand();
        return w;
    endfunction

    // word-aligned address within the conflict pool
    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        return POOL_BASE + (r[31:16] % POOL_LINES) * 32 + r[11:10] * 8;
    endfunction

    function automatic word_t init_word(addr_t a);
        return {a * 32'h9e37_79b9, a ^ 32'hc35a_1e0f};
    endfunction

    function automatic word_t model_word(addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
    endfunction

    function automatic word_t apply_op(core_req_t r, word_t old);
        word_t              res;
        logic signed [63:0] s_old;
        logic signed [63:0] s_arg;
        s_old = old;
        s_arg = r.wdata;
        res = old;
        if (r.op == op_store) begin
            for (int b = 0; b < 8; b++) begin
                if (r.wstrb[b]) begin
                    res[8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
        end else if (r.op == op_amo) begin
            case (r.amo)
                amo_swap: res = r.wdata;
                amo_add:  res = old + r.wdata;
                amo_xor:  res = old ^ r.wdata;
                amo_and:  res = old & r.wdata;
                amo_or:   res = old | r.wdata;
                amo_min:  res = (s_arg < s_old) ? r.wdata : old;
                amo_max:  res = (s_arg > s_old) ? r.wdata : old;
                amo_minu: res = (r.wdata < old) ? r.wdata : old;
                amo_maxu: res = (r.wdata > old) ? r.wdata : old;
                default:  res = old;
            endcase
        end
        return res;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_line_addr(input string what, input line_addr_t exp,
                                   input line_addr_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input logic cond, input string text);
        n_checks++;
        if (cond !== 1'b1) begin
            n_errors++;
            $display("error in %s: %s", test_name, text);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        checks_at_start = n_checks;
        errors_at_start = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %-10s %0d checks, %0d errors", test_name,
                 n_checks - checks_at_start, n_errors - errors_at_start);
    endtask

    // one request, checked against the reference memory and a shadow of the tags
    task automatic access(input op_e op, input amo_e amo, input addr_t addr,
                          input word_t wdata, input strb_t wstrb);
        core_req_t  r;
        line_addr_t la;
        line_addr_t victim;
        int         idx;
        int         cycles;
        logic       hit;
        logic       wb_due;
        logic       saw_rd;
        logic       saw_wb;
        word_t      old;
        r.op    = op;
        r.amo   = amo;
        r.addr  = addr;
        r.wdata = wdata;
        r.wstrb = wstrb;
        la      = addr[ADDR_WIDTH-1:OFFSET_WIDTH];
        idx     = la % DEPTH;
        victim  = shadow_line[idx];
        hit     = shadow_valid[idx] && (shadow_line[idx] == la);
        wb_due  = !hit && shadow_valid[idx] && shadow_dirty[idx];
        old     = model_word(addr);

        @(posedge CLK);
        #2;
        req       = r;
        req_valid = 1'b1;
        check_flag(req_ready, "req_ready low while the cache is idle");
        @(posedge CLK);
        #2;
        req_valid = 1'b0;
        cycles = 0;
        saw_rd = 1'b0;
        saw_wb = 1'b0;
        do begin
            @(posedge CLK);
            #1;
            cycles++;
            if (l2_rd_valid && !saw_rd) begin
                saw_rd = 1'b1;
                check_line_addr("refill address", la, l2_rd_addr);
            end
            if (l2_wb_valid && !saw_wb) begin
                saw_wb = 1'b1;
                n_wb++;
                check_line_addr("write-back address", victim, l2_wb.addr);
                for (int w = 0; w < BLOCK_WORDS; w++) begin
                    check_word("write-back data", model_word({victim, 5'b0} + w * 8),
                               l2_wb.data[w*WORD_WIDTH +: WORD_WIDTH]);
                end
            end
        end while (!rsp_valid);

        check_word("response", old, rsp_data);
        if (hit) begin
            check_flag(!saw_rd, "L2 read issued on a hit");
            check_flag(cycles == ((op == op_amo) ? 3 : 2), "hit response came at the wrong cycle");
        end else begin
            check_flag(saw_rd, "miss completed without an L2 read");
        end
        check_flag(saw_wb == wb_due, "write-back does not match the victim's dirty state");

        if (op != op_load) begin
            ref_mem[addr] = apply_op(r, old);
        end
        if (!hit) begin
            shadow_dirty[idx] = 1'b0;
        end
        shadow_valid[idx] = 1'b1;
        shadow_line[idx]  = la;
        if (op != op_load) begin
            shadow_dirty[idx] = 1'b1;
        end
    endtask

    initial begin
        addr_t       a;
        word_t       w;
        logic [31:0] r;
        RST          = 1'b1;
        req          = '0;
        req_valid    = 1'b0;
        shadow_valid = '0;
        shadow_dirty = '0;
        repeat (16) @(posedge CLK);
        #2;
        RST = 1'b0;
        @(posedge CLK);
        #1;

        begin_test("reset");
        check_flag(req_ready, "req_ready low after reset");
        check_flag(!rsp_valid, "rsp_valid high after reset");
        check_flag(!l2_rd_valid, "l2_rd_valid high after reset");
        check_flag(!l2_wb_valid, "l2_wb_valid high after reset");
        end_test();

        begin_test("loads");
        repeat (N_LOADS) access(op_load, amo_swap, rand_addr(), '0, '0);
        end_test();

        begin_test("stores");
        repeat (N_STORES) begin
            a = rand_addr();
            w = rand_word();
            access(op_store, amo_swap, a, w, strb_t'(next_rand() >> 20));
            access(op_load, amo_swap, a, '0, '0);
        end
        end_test();

        begin_test("amo");
        for (int k = 0; k < N_AMOS; k++) begin
            a = rand_addr();
            w = rand_word();
            access(op_amo, amo_e'(4'(k % 9)), a, w, '1);
            access(op_load, amo_swap, a, '0, '0);
        end
        end_test();

        // mixed traffic over the pool keeps evicting dirty lines
        begin_test("evict");
        repeat (N_MIX) begin
            r = next_rand();
            a = rand_addr();
            w = rand_word();
            case (r[31:30])
                2'd2:    access(op_store, amo_swap, a, w, strb_t'(r >> 8));
                2'd3:    access(op_amo, amo_e'(4'(r[15:12] % 9)), a, w, '1);
                default: access(op_load, amo_swap, a, '0, '0);
            endcase
        end
        check_flag(l2_0.wb_count == n_wb, "L2 model write-back count differs from the bus");
        end_test();

        begin_test("hit_repeat");
        repeat (N_REPEAT) begin
            a = rand_addr();
            access(op_load, amo_swap, a, '0, '0);
            access(op_load, amo_swap, a, '0, '0);
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* test/l2_mem_model.sv */
`timescale 1ns/1ps

module l2_mem_model
    import dcache_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       l2_rd_valid,
    input  line_addr_t l2_rd_addr,
    output logic       l2_fill_valid,
    output line_t      l2_fill_data,
    input  logic       l2_wb_valid,
    input  l2_wb_t     l2_wb,
    output logic       l2_wb_done
);

    line_t       mem [line_addr_t];
    logic [31:0] seed = 32'hbc62;
    int          wb_count = 0;

    // same fill pattern as the testbench reference
    function automatic word_t init_word(addr_t a);
        return {a * 32'h9e37_79b9, a ^ 32'hc35a_1e0f};
    endfunction

    function automatic line_t read_line(line_addr_t la);
        line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            l[i*WORD_WIDTH +: WORD_WIDTH] = init_word({la, 5'b0} + i * 8);
        end
        return l;
    endfunction

    function automatic int rand_delay();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[18:16];
    endfunction

    initial begin
        l2_fill_valid = 1'b0;
        l2_fill_data  = '0;
        l2_wb_done    = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            if (!RST && l2_wb_valid) begin
                repeat (rand_delay()) @(posedge CLK);
                #2;
                mem[l2_wb.addr] = l2_wb.data;
                wb_count++;
                l2_wb_done = 1'b1;
                @(posedge CLK);
                #2;
                l2_wb_done = 1'b0;
            end else if (!RST && l2_rd_valid) begin
                repeat (rand_delay()) @(posedge CLK);
                #2;
                l2_fill_data  = read_line(l2_rd_addr);
                l2_fill_valid = 1'b1;
                @(posedge CLK);
                #2;
                l2_fill_valid = 1'b0;
            end
        end
    end

endmodule
